//--- bench/laneTb.sv
// Lane testbench: drives instructions into laneTop, models memory and checks every writeback
`timescale 1ns/10ps
`include "lane_consts.svh"

module laneTb;

	import lanePkg::*;

	logic			clock;
	logic			arstN;
	logic			instrValid;
	logic [31:0]		instrWord;
	logic			branchFlush;
	logic			memRead;
	logic [`LANE_XLEN-1:0]	memAddr;
	logic [`LANE_XLEN-1:0]	memDataIn;
	logic			wbValid;
	logic [`LANE_RID_W-1:0]	wbRegId;
	logic [`LANE_XLEN-1:0]	wbValue;

	logic [`LANE_XLEN-1:0]	modelRegs [0:63];	// Architectural view, updated at issue
	int			readyAt [0:63];	// First cycle a reader may issue
	logic [`LANE_RID_W-1:0]	wbIdQ [$];
	logic [`LANE_XLEN-1:0]	wbValQ [$];
	int			wbCycQ [$];	// Expected arrival cycle
	logic [`LANE_XLEN-1:0]	addrQ [$];	// Expected load addresses
	logic [`LANE_XLEN-1:0]	expAddr;
	logic [`LANE_XLEN-1:0]	expVal;
	logic [`LANE_RID_W-1:0]	expId;
	int			expCyc;
	int			cycleCount = 0;
	int			checkCount = 0;
	int			errorCount = 0;
	int			testErrors;
	logic [5:0]		rOpc;
	logic [5:0]		rRd;
	logic [5:0]		rRs;
	logic [13:0]		rImm;
	int			guard;

	laneTop i_laneTop (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;	// 100 ns period
	end

	always @(posedge clock) cycleCount++;

	function automatic logic [63:0] memValue(input logic [63:0] addr);
		return {addr[50:0], addr[63:51]} ^ 64'hA5A5_0F0F_3C3C_9696;	// Rotate left 13
	endfunction

	always @(negedge clock) memDataIn = memValue(memAddr);	// Memory answers next edge

	function automatic logic [63:0] sext14(input logic [13:0] imm);
		return {{50{imm[13]}}, imm};
	endfunction

	function automatic logic [63:0] regRead(input logic [5:0] id);
		return (id == `LANE_ZZR) ? 64'd0 : modelRegs[id];
	endfunction

	function automatic bit writesBack(input logic [31:0] word);
		return (word[31:26] >= 6'd1) && (word[31:26] <= 6'd7) && (word[25:20] != `LANE_ZZR);
	endfunction

	// Expected writeback value from the model register file
	function automatic logic [63:0] refResult(input logic [31:0] word);
		logic [63:0]		a;
		logic [63:0]		b;
		logic signed [63:0]	pa;
		logic signed [63:0]	pb;
		a = regRead(word[19:14]);
		b = regRead(word[13:8]);
		pa = $signed(a[31:0]);	// Low words only
		pb = $signed(b[31:0]);
		case (word[31:26])
			opMovIr: return sext14(word[13:0]);
			opAdd:   return a + b;
			opSub:   return a - b;
			opAnd:   return a & b;
			opXor:   return a ^ b;
			opMulw:  return pa * pb;
			opLoad:  return memValue(a + sext14(word[13:0]));
			default: return 64'd0;
		endcase
	endfunction

	function automatic logic [31:0] rType(input logic [5:0] opc, rd, rs, rt);
		return {opc, rd, rs, rt, 8'h00};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] opc, rd, rs, input logic [13:0] imm);
		return {opc, rd, rs, imm};
	endfunction

	// Issue one instruction; keep low means it will be flushed
	task automatic drive(input logic [31:0] word, input bit keep);
		logic [63:0] value;
		@(negedge clock);
		instrValid = 1'b1;
		instrWord = word;
		branchFlush = 1'b0;
		if (word[31:26] == opLoad) addrQ.push_back(regRead(word[19:14]) + sext14(word[13:0]));
		if (keep && writesBack(word)) begin
			value = refResult(word);
			wbIdQ.push_back(word[25:20]);
			wbValQ.push_back(value);
			wbCycQ.push_back(cycleCount + 4);	// Fixed 4-edge latency
			modelRegs[word[25:20]] = value;
			readyAt[word[25:20]] = cycleCount + 5;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clock);
			instrValid = 1'b0;
			instrWord = 32'd0;
			branchFlush = 1'b0;
		end
	endtask

	task automatic drain();
		guard = 0;
		while ((wbIdQ.size() != 0 || addrQ.size() != 0) && guard < 20) begin
			idle(1);
			guard++;
		end
		if (wbIdQ.size() != 0 || addrQ.size() != 0) begin
			$display("Timeout: %0d writebacks and %0d loads never arrived", wbIdQ.size(),
				addrQ.size());
			errorCount++;
			wbIdQ.delete();
			wbValQ.delete();
			wbCycQ.delete();
			addrQ.delete();	// Next test starts with empty queues
		end
	endtask

	task automatic finishTest(input string name);
		idle(2);
		drain();
		$display("Test %s finished with %0d errors", name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	// Compares every load request and writeback against the queues
	always @(negedge clock) begin
		if (arstN && memRead) begin
			checkCount++;
			if (addrQ.size() == 0) begin
				$display("Error at %0t: memRead raised with no load in flight", $time);
				errorCount++;
			end else begin
				expAddr = addrQ.pop_front();
				if (memAddr !== expAddr) begin
					$display("Mismatch at %0t: memAddr expected %h got %h", $time, expAddr, memAddr);
					errorCount++;
				end
			end
		end
		if (arstN && wbValid) begin
			checkCount++;
			if (wbIdQ.size() == 0) begin
				$display("Error at %0t: writeback to r%0d that should not happen", $time, wbRegId);
				errorCount++;
			end else begin
				expId = wbIdQ.pop_front();
				expVal = wbValQ.pop_front();
				expCyc = wbCycQ.pop_front();
				if (wbRegId !== expId) begin
					$display("Mismatch at %0t: wbRegId expected %0d got %0d", $time, expId, wbRegId);
					errorCount++;
				end
				if (wbValue !== expVal) begin
					$display("Mismatch at %0t: wbValue expected %h got %h", $time, expVal, wbValue);
					errorCount++;
				end
				if (cycleCount != expCyc) begin
					$display("Error at %0t: writeback arrived %0d cycles off the 4-edge latency",
						$time, cycleCount - expCyc);
					errorCount++;
				end
			end
		end
	end

	initial begin
		void'($urandom(32'h94b6_ccee));	// Single seed for the run
		arstN = 1'b0;
		instrValid = 1'b0;
		instrWord = 32'd0;
		branchFlush = 1'b0;
		memDataIn = 64'd0;
		testErrors = 0;
		for (int i = 0; i < 64; i++) begin
			modelRegs[i] = 64'd0;
			readyAt[i] = 0;
		end
		repeat (5) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;

		repeat (10) begin
			@(negedge clock);
			checkCount++;
			if (wbValid || memRead) begin
				$display("Error at %0t: wbValid or memRead active while idle", $time);
				errorCount++;
			end
		end
		drive(iType(opMovIr, 6'd0, 6'd0, 14'h2000), 1'b1);	// Most negative
		drive(iType(opMovIr, 6'd5, 6'd0, 14'h1FFF), 1'b1);
		drive(iType(opMovIr, 6'd17, 6'd0, 14'h3FFF), 1'b1);
		drive(iType(opMovIr, 6'd40, 6'd0, 14'h0123), 1'b1);
		finishTest("movIr");

		for (int r = 1; r <= 4; r++) drive(iType(opMovIr, 6'(r), 6'd0, 14'($urandom())), 1'b1);
		idle(4);
		drive(rType(opAdd, 6'd10, 6'd1, 6'd2), 1'b1);	// Independent, back-to-back
		drive(rType(opSub, 6'd11, 6'd3, 6'd4), 1'b1);
		drive(rType(opAnd, 6'd12, 6'd1, 6'd3), 1'b1);
		drive(rType(opXor, 6'd13, 6'd2, 6'd4), 1'b1);
		drive(rType(opMulw, 6'd14, 6'd1, 6'd2), 1'b1);
		idle(4);
		drive(rType(opMulw, 6'd15, 6'd10, 6'd11), 1'b1);	// Depends on add and sub
		drive(rType(opXor, 6'd16, 6'd12, 6'd13), 1'b1);
		finishTest("alu and mulw");

		drive(iType(opMovIr, 6'd20, 6'd0, 14'($urandom())), 1'b1);
		idle(4);
		drive(iType(opLoad, 6'd21, 6'd20, 14'h0040), 1'b1);
		drive(iType(opLoad, 6'd22, 6'd20, 14'h3FC0), 1'b1);	// Negative offset
		drive(iType(opLoad, 6'd23, `LANE_ZZR, 14'h1234), 1'b1);
		finishTest("load");

		drive(iType(opMovIr, 6'd30, 6'd0, 14'd123), 1'b1);
		drive(iType(opMovIr, 6'd31, 6'd0, 14'd456), 1'b1);
		drive(iType(opMovIr, 6'd32, 6'd0, 14'd789), 1'b1);
		idle(4);
		drive(iType(opMovIr, 6'd30, 6'd0, 14'd1), 1'b1);
		drive(iType(opMovIr, 6'd31, 6'd0, 14'd2), 1'b0);	// Gets flushed
		drive(iType(opMovIr, 6'd32, 6'd0, 14'd3), 1'b1);
		idle(1);
		@(negedge clock);
		instrValid = 1'b0;
		branchFlush = 1'b1;	// Result stage holds the r31 write
		idle(3);
		drive(rType(opAdd, 6'd33, 6'd31, `LANE_ZZR), 1'b1);	// Expect old 456
		finishTest("branch flush");

		drive(iType(opMovIr, 6'd8, 6'd0, 14'd77), 1'b1);
		drive(iType(6'd8, 6'd9, 6'd0, 14'd5), 1'b1);	// Undefined opcodes
		drive(iType(6'd45, 6'd9, 6'd0, 14'd5), 1'b1);
		drive(iType(6'd63, 6'd9, 6'd0, 14'd5), 1'b1);
		drive(iType(opMovIr, `LANE_ZZR, 6'd0, 14'd99), 1'b1);
		drive(rType(opAdd, `LANE_ZZR, 6'd8, 6'd8), 1'b1);
		idle(4);
		drive(rType(opAdd, 6'd7, `LANE_ZZR, `LANE_ZZR), 1'b1);
		drive(rType(opXor, 6'd9, 6'd8, `LANE_ZZR), 1'b1);
		finishTest("undefined and zero register");

		for (int n = 0; n < 200; n++) begin
			rOpc = 6'($urandom_range(9, 0));	// 8 and 9 are undefined
			rRd = 6'($urandom_range(63, 0));
			rRs = 6'($urandom_range(63, 0));
			rImm = 14'($urandom_range(16383, 0));
			guard = 0;
			while ((cycleCount + 1 < readyAt[rRs] || cycleCount + 1 < readyAt[rImm[13:8]])
				&& guard < 10) begin
				idle(1);	// Hold off until sources are written
				guard++;
			end
			drive(iType(rOpc, rRd, rRs, rImm), 1'b1);
		end
		finishTest("random mix");

		$display("Summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- include/lane_consts.svh
// Lane-wide width and instruction-field macros; include wherever widths or fields are needed
`ifndef LANE_CONSTS_SVH
`define LANE_CONSTS_SVH

`define LANE_XLEN	64	// Data path width
`define LANE_RID_W	6	// Register id width
`define LANE_ZZR	6'd63	// Zero register, reads 0, drops writes

// Instruction word fields
`define LANE_OPC_HI	31
`define LANE_OPC_LO	26
`define LANE_OPC_W	6
`define LANE_RD_HI	25	// Destination
`define LANE_RD_LO	20
`define LANE_RD_W	6
`define LANE_RS_HI	19	// Source A
`define LANE_RS_LO	14
`define LANE_RS_W	6
`define LANE_RT_HI	13	// Source B, register forms only
`define LANE_RT_LO	8
`define LANE_RT_W	6
`define LANE_IMM_HI	13	// Signed immediate, shares bits with source B
`define LANE_IMM_LO	0
`define LANE_IMM_W	14

`endif

//--- rtl/laneAlu.sv
// First execute stage: ALU results, move-immediate and load address, registered at edge 2
`timescale 1ns/10ps
`include "lane_consts.svh"

module laneAlu (
	input  logic			clock,
	input  logic			arstN,
	input  logic			dValid,
	input  lanePkg::laneUCmd	dUCmd,
	input  lanePkg::laneAluOp	dAluOp,
	input  logic [`LANE_RID_W-1:0]	dRegIdRn,
	input  logic [`LANE_XLEN-1:0]	dValA,
	input  logic [`LANE_XLEN-1:0]	dValB,
	input  logic [`LANE_XLEN-1:0]	dImm,
	output logic			aValid,
	output lanePkg::laneUCmd	aUCmd,
	output logic [`LANE_RID_W-1:0]	aRegIdRn,
	output logic [`LANE_XLEN-1:0]	aRes,		// ALU result or load address
	output logic [`LANE_XLEN-1:0]	aMulA,		// Sign-extended low word of A
	output logic [`LANE_XLEN-1:0]	aMulB		// Sign-extended low word of B
);

	import lanePkg::*;

	logic [`LANE_XLEN-1:0]	aluOut;
	logic [`LANE_XLEN-1:0]	resNext;

	always_comb begin
		case (dAluOp)
			aluAdd:  aluOut = dValA + dValB;
			aluSub:  aluOut = dValA - dValB;
			aluAnd:  aluOut = dValA & dValB;
			default: aluOut = dValA ^ dValB;	// aluXor
		endcase
	end

	always_comb begin
		resNext = '0;	// Mulw fills this in next stage
		case (dUCmd)
			ucAlu:   resNext = aluOut;
			ucMovIr: resNext = dImm;
			ucLoad:  resNext = dValA + dImm;	// Effective address
			default: resNext = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			aValid <= 1'b0;
			aUCmd  <= ucNop;
		end else begin
			aValid <= dValid;
			aUCmd  <= dUCmd;
		end
	end

	always_ff @(posedge clock) begin
		aRegIdRn <= dRegIdRn;
		aRes     <= resNext;
		aMulA    <= {{32{dValA[31]}}, dValA[31:0]};	// Only low word is multiplied
		aMulB    <= {{32{dValB[31]}}, dValB[31:0]};
	end

endmodule

//--- rtl/laneDecode.sv
// Decode stage: splits the instruction, picks the micro-command and latches operands at edge 1
`timescale 1ns/10ps
`include "lane_consts.svh"

module laneDecode (
	input  logic			clock,
	input  logic			arstN,
	input  logic			instrValid,	// One-cycle strobe
	input  logic [31:0]		instrWord,
	input  logic [`LANE_XLEN-1:0]	regValA,	// From register file
	input  logic [`LANE_XLEN-1:0]	regValB,
	output logic [`LANE_RID_W-1:0]	regIdA,		// To register file
	output logic [`LANE_RID_W-1:0]	regIdB,
	output logic			dValid,
	output lanePkg::laneUCmd	dUCmd,
	output lanePkg::laneAluOp	dAluOp,
	output logic [`LANE_RID_W-1:0]	dRegIdRn,	// Destination id
	output logic [`LANE_XLEN-1:0]	dValA,
	output logic [`LANE_XLEN-1:0]	dValB,
	output logic [`LANE_XLEN-1:0]	dImm		// Sign-extended immediate
);

	import lanePkg::*;

	logic [`LANE_OPC_W-1:0]	opcField;
	logic [`LANE_RD_W-1:0]	rdField;
	logic [`LANE_RS_W-1:0]	rsField;
	logic [`LANE_RT_W-1:0]	rtField;
	logic [`LANE_IMM_W-1:0]	immField;
	laneOpcode		opc;
	laneUCmd		nextUCmd;
	laneAluOp		nextAluOp;
	logic [`LANE_XLEN-1:0]	immSext;

	assign opcField = instrWord[`LANE_OPC_HI:`LANE_OPC_LO];
	assign rdField  = instrWord[`LANE_RD_HI:`LANE_RD_LO];
	assign rsField  = instrWord[`LANE_RS_HI:`LANE_RS_LO];
	assign rtField  = instrWord[`LANE_RT_HI:`LANE_RT_LO];
	assign immField = instrWord[`LANE_IMM_HI:`LANE_IMM_LO];

	assign regIdA  = rsField;	// Operand read happens before edge 1
	assign regIdB  = rtField;
	assign immSext = {{(`LANE_XLEN - `LANE_IMM_W){immField[`LANE_IMM_W-1]}}, immField};
	assign opc     = laneOpcode'(opcField);

	always_comb begin
		nextUCmd  = ucNop;
		nextAluOp = aluAdd;
		case (opc)
			opMovIr: nextUCmd = ucMovIr;
			opAdd: begin
				nextUCmd  = ucAlu;
				nextAluOp = aluAdd;
			end
			opSub: begin
				nextUCmd  = ucAlu;
				nextAluOp = aluSub;
			end
			opAnd: begin
				nextUCmd  = ucAlu;
				nextAluOp = aluAnd;
			end
			opXor: begin
				nextUCmd  = ucAlu;
				nextAluOp = aluXor;
			end
			opMulw: nextUCmd = ucMulw;
			opLoad: nextUCmd = ucLoad;	// Address = A + imm
			default: nextUCmd = ucNop;	// opNop and undefined codes
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			dValid <= 1'b0;
			dUCmd  <= ucNop;
		end else begin
			dValid <= instrValid;
			dUCmd  <= instrValid ? nextUCmd : ucNop;	// Idle cycles carry nop
		end
	end

	always_ff @(posedge clock) begin
		dAluOp   <= nextAluOp;
		dRegIdRn <= rdField;
		dValA    <= regValA;
		dValB    <= regValB;
		dImm     <= immSext;
	end

endmodule

//--- rtl/laneMulMem.sv
// Second execute stage: signed word multiply and load request, registered at edge 3
`timescale 1ns/10ps
`include "lane_consts.svh"

module laneMulMem (
	input  logic			clock,
	input  logic			arstN,
	input  logic			aValid,
	input  lanePkg::laneUCmd	aUCmd,
	input  logic [`LANE_RID_W-1:0]	aRegIdRn,
	input  logic [`LANE_XLEN-1:0]	aRes,
	input  logic [`LANE_XLEN-1:0]	aMulA,
	input  logic [`LANE_XLEN-1:0]	aMulB,
	output logic			mValid,
	output lanePkg::laneUCmd	mUCmd,
	output logic [`LANE_RID_W-1:0]	mRegIdRn,
	output logic [`LANE_XLEN-1:0]	mRes,
	output logic			memRead,	// One-cycle load strobe
	output logic [`LANE_XLEN-1:0]	memAddr
);

	import lanePkg::*;

	logic signed [`LANE_XLEN-1:0]	product;

	// Operands arrive sign-extended so the low 64 bits hold the full product
	assign product = $signed(aMulA) * $signed(aMulB);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			mValid  <= 1'b0;
			mUCmd   <= ucNop;
			memRead <= 1'b0;
		end else begin
			mValid  <= aValid;
			mUCmd   <= aUCmd;
			memRead <= aValid && (aUCmd == ucLoad);	// Memory answers before edge 4
		end
	end

	always_ff @(posedge clock) begin
		mRegIdRn <= aRegIdRn;
		mRes     <= (aUCmd == ucMulw) ? product : aRes;
		memAddr  <= aRes;	// Address from laneAlu
	end

endmodule

//--- rtl/lanePkg.sv
// Opcode, micro-command and ALU sub-operation types shared by the lane stages
package lanePkg;

	// Architectural opcodes, anything else decodes as a nop
	typedef enum logic [5:0] {
		opNop	= 6'd0,
		opMovIr	= 6'd1,	// Rd = sext(imm)
		opAdd	= 6'd2,
		opSub	= 6'd3,
		opAnd	= 6'd4,
		opXor	= 6'd5,
		opMulw	= 6'd6,	// Signed 32x32 to 64
		opLoad	= 6'd7	// Rd = mem[Rs + sext(imm)]
	} laneOpcode;

	// Micro-commands carried down the pipe
	typedef enum logic [3:0] {
		ucNop	= 4'd0,
		ucMovIr	= 4'd1,
		ucAlu	= 4'd2,	// Sub-operation in laneAluOp
		ucMulw	= 4'd3,
		ucLoad	= 4'd4
	} laneUCmd;

	// ALU sub-operations for ucAlu
	typedef enum logic [1:0] {
		aluAdd	= 2'd0,
		aluSub	= 2'd1,
		aluAnd	= 2'd2,
		aluXor	= 2'd3
	} laneAluOp;

endpackage

//--- rtl/laneRegFile.sv
// General register file of the lane, two combinational reads and one write fed by writeback
`timescale 1ns/10ps
`include "lane_consts.svh"

module laneRegFile (
	input  logic			clock,
	input  logic			arstN,
	input  logic [`LANE_RID_W-1:0]	readIdA,	// Source A id
	input  logic [`LANE_RID_W-1:0]	readIdB,	// Source B id
	input  logic			writeEn,
	input  logic [`LANE_RID_W-1:0]	writeId,
	input  logic [`LANE_XLEN-1:0]	writeData,
	output logic [`LANE_XLEN-1:0]	readDataA,
	output logic [`LANE_XLEN-1:0]	readDataB
);

	logic [`LANE_XLEN-1:0]	regs [0:`LANE_ZZR-1];	// 63 real registers, ZZR has no storage

	// Zero register reads as constant
	assign readDataA = (readIdA == `LANE_ZZR) ? '0 : regs[readIdA];
	assign readDataB = (readIdB == `LANE_ZZR) ? '0 : regs[readIdB];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `LANE_ZZR; i++) begin
				regs[i] <= '0;	// Architectural state starts at zero
			end
		end else if (writeEn && (writeId != `LANE_ZZR)) begin
			regs[writeId] <= writeData;	// Writes to ZZR dropped
		end
	end

endmodule

//--- rtl/laneResult.sv
// Third execute stage: chooses final destination and value, applies flush, drives writeback
`timescale 1ns/10ps
`include "lane_consts.svh"

module laneResult (
	input  logic			clock,
	input  logic			arstN,
	input  logic			mValid,
	input  lanePkg::laneUCmd	mUCmd,
	input  logic [`LANE_RID_W-1:0]	mRegIdRn,
	input  logic [`LANE_XLEN-1:0]	mRes,
	input  logic [`LANE_XLEN-1:0]	memDataIn,	// Load data for this cycle
	input  logic			branchFlush,	// Kills the op in this stage
	output logic			wbValid,
	output logic [`LANE_RID_W-1:0]	wbRegId,
	output logic [`LANE_XLEN-1:0]	wbValue
);

	import lanePkg::*;

	logic [`LANE_RID_W-1:0]	finalId;
	logic [`LANE_XLEN-1:0]	finalVal;
	logic			finalEn;

	always_comb begin
		finalId  = mRegIdRn;	// Forward by default
		finalVal = mRes;
		if (mUCmd == ucLoad) begin
			finalVal = memDataIn;	// Load replaces address with data
		end
		if (branchFlush) begin
			finalId = `LANE_ZZR;	// Flushed op writes nowhere
		end
	end

	assign finalEn = mValid && (mUCmd != ucNop) && (finalId != `LANE_ZZR);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= finalEn;
		end
	end

	always_ff @(posedge clock) begin
		wbRegId <= finalId;
		wbValue <= finalVal;
	end

endmodule

//--- rtl/laneTop.sv
// Lane top level connecting decode, two execute stages, result stage and register file
`timescale 1ns/10ps
`include "lane_consts.svh"

module laneTop (
	input  logic			clock,
	input  logic			arstN,
	input  logic			instrValid,
	input  logic [31:0]		instrWord,
	input  logic			branchFlush,
	output logic			memRead,
	output logic [`LANE_XLEN-1:0]	memAddr,
	input  logic [`LANE_XLEN-1:0]	memDataIn,
	output logic			wbValid,
	output logic [`LANE_RID_W-1:0]	wbRegId,
	output logic [`LANE_XLEN-1:0]	wbValue
);

	import lanePkg::*;

	logic [`LANE_RID_W-1:0]	regIdA;		// Decode read ports
	logic [`LANE_RID_W-1:0]	regIdB;
	logic [`LANE_XLEN-1:0]	regValA;
	logic [`LANE_XLEN-1:0]	regValB;

	logic			dValid;		// Decode to ALU
	laneUCmd		dUCmd;
	laneAluOp		dAluOp;
	logic [`LANE_RID_W-1:0]	dRegIdRn;
	logic [`LANE_XLEN-1:0]	dValA;
	logic [`LANE_XLEN-1:0]	dValB;
	logic [`LANE_XLEN-1:0]	dImm;

	logic			aValid;		// ALU to multiply/memory
	laneUCmd		aUCmd;
	logic [`LANE_RID_W-1:0]	aRegIdRn;
	logic [`LANE_XLEN-1:0]	aRes;
	logic [`LANE_XLEN-1:0]	aMulA;
	logic [`LANE_XLEN-1:0]	aMulB;

	logic			mValid;		// Multiply/memory to result
	laneUCmd		mUCmd;
	logic [`LANE_RID_W-1:0]	mRegIdRn;
	logic [`LANE_XLEN-1:0]	mRes;

	laneRegFile i_laneRegFile (
		.clock, .arstN,
		.readIdA(regIdA), .readIdB(regIdB),
		.writeEn(wbValid), .writeId(wbRegId), .writeData(wbValue),	// Written at edge 5
		.readDataA(regValA), .readDataB(regValB)
	);

	laneDecode i_laneDecode (
		.clock, .arstN, .instrValid, .instrWord, .regValA, .regValB,
		.regIdA, .regIdB, .dValid, .dUCmd, .dAluOp, .dRegIdRn, .dValA, .dValB, .dImm
	);

	laneAlu i_laneAlu (
		.clock, .arstN, .dValid, .dUCmd, .dAluOp, .dRegIdRn, .dValA, .dValB, .dImm,
		.aValid, .aUCmd, .aRegIdRn, .aRes, .aMulA, .aMulB
	);

	laneMulMem i_laneMulMem (
		.clock, .arstN, .aValid, .aUCmd, .aRegIdRn, .aRes, .aMulA, .aMulB,
		.mValid, .mUCmd, .mRegIdRn, .mRes, .memRead, .memAddr
	);

	laneResult i_laneResult (
		.clock, .arstN, .mValid, .mUCmd, .mRegIdRn, .mRes, .memDataIn, .branchFlush,
		.wbValid, .wbRegId, .wbValue
	);

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the lane testbench with Verilator, run it, and pass only if the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f sim.f --top-module laneTb -o laneSim &&
./obj_dir/laneSim | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- sim.f
+incdir+include
rtl/lanePkg.sv
rtl/laneRegFile.sv
rtl/laneDecode.sv
rtl/laneAlu.sv
rtl/laneMulMem.sv
rtl/laneResult.sv
rtl/laneTop.sv
bench/laneTb.sv
